/* prefetch_subsystem.f */
+incdir+src
src/prefetch_pkg.sv
src/prefetch_buffer.sv
src/stream_fetcher.sv
src/read_arbiter.sv
src/shared_memory.sv
src/prefetch_subsystem.sv
sim/tb_prefetch_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the prefetcher testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_prefetch_subsystem \
    -f prefetch_subsystem.f -o sim_prefetch

output=$(./obj_dir/sim_prefetch)
echo "$output"

if echo "$output" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

/* sim/tb_prefetch_subsystem.sv */
// Testbench for the dual-stream prefetcher
// LFSR memory contents and consumer stalls, assertion checks, cycle timeout

`default_nettype none

`include "prefetch_config.svh"

module tb_prefetch_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    // Sum of all run lengths below sets the timeout
    localparam int TOTAL_WORDS = 20 + 24 + 20 + 24 + 24 + 16 + 12;
    localparam int TIMEOUT     = 4 * TOTAL_WORDS * 8 + 200;

    logic clk = 1'b0;
    logic srst = 1'b1;
    logic load_en = 1'b0, s0_start = 1'b0, s1_start = 1'b0, s0_rd = 1'b0, s1_rd = 1'b0;
    prefetch_pkg::addr_t  load_addr = '0, s0_base_addr = '0, s1_base_addr = '0;
    prefetch_pkg::data_t  load_data = '0, s0_rd_data, s1_rd_data;
    prefetch_pkg::count_t s0_word_count = '0, s1_word_count = '0;
    logic s0_busy, s1_busy, s0_rd_rdy, s1_rd_rdy, s0_oflow, s1_oflow;

    // Reference copy of the RAM and per-stream expected words
    prefetch_pkg::data_t mem_copy [`PF_MEM_WORDS];
    prefetch_pkg::data_t exp_data [2][256];
    int          exp_wr [2] = '{0, 0};
    int          exp_rd [2] = '{0, 0};
    int          errors = 0, pops = 0, cycle = 0, fall0 = 0, fall1 = 0;
    int          hold0 = 0, hold1 = 0;
    logic        rand_rd = 1'b0, lvl0 = 1'b1, lvl1 = 1'b1;
    logic [31:0] lfsr_state = 32'h73ce_5f25;

    prefetch_subsystem u_dut (.*);

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic log_error(input string msg);
        errors++;
        $display("FAIL t=%0t %s", $time, msg);
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return v;
    endfunction

    // Short read bursts between long stalls
    // A stall outlasts the time the returns need to fill a buffer with no headroom
    task automatic pick_stretch(output logic lvl, output int hold);
        lvl  = (rand_bits(1) != 0);
        hold = lvl ? 1 + int'(rand_bits(3)) : 64 + int'(rand_bits(5));
    endtask

    task automatic load_memory();
        prefetch_pkg::data_t word;
        for (int a = 0; a < `PF_MEM_WORDS; a++) begin
            word = prefetch_pkg::data_t'(rand_bits(`PF_DATA_W));
            mem_copy[a] = word;
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= prefetch_pkg::addr_t'(a);
            load_data <= word;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic start_runs(input logic go0, input prefetch_pkg::addr_t b0,
                              input prefetch_pkg::count_t n0, input logic go1,
                              input prefetch_pkg::addr_t b1, input prefetch_pkg::count_t n1);
        // Expected words queued before start reaches the DUT
        for (int i = 0; i < (go0 ? int'(n0) : 0); i++) begin
            exp_data[0][exp_wr[0]] = mem_copy[int'(b0) + i];
            exp_wr[0]++;
        end
        for (int i = 0; i < (go1 ? int'(n1) : 0); i++) begin
            exp_data[1][exp_wr[1]] = mem_copy[int'(b1) + i];
            exp_wr[1]++;
        end
        @(posedge clk);
        s0_start      <= go0;
        s0_base_addr  <= b0;
        s0_word_count <= n0;
        s1_start      <= go1;
        s1_base_addr  <= b1;
        s1_word_count <= n1;
        @(posedge clk);
        s0_start <= 1'b0;
        s1_start <= 1'b0;
    endtask

    // Busy falls recorded in cycles, for the fairness check
    task automatic wait_runs_done();
        logic prev0, prev1;
        prev0 = 1'b0;
        prev1 = 1'b0;
        do begin
            @(negedge clk);
            if (prev0 && !s0_busy)
                fall0 = cycle;
            if (prev1 && !s1_busy)
                fall1 = cycle;
            prev0 = s0_busy;
            prev1 = s1_busy;
        end while (s0_busy || s1_busy || exp_rd[0] != exp_wr[0] || exp_rd[1] != exp_wr[1]);
        // Late stray words would show up here
        repeat (4) @(negedge clk);
        a_idle: assert (!s0_busy && !s1_busy && !s0_rd_rdy && !s1_rd_rdy)
            else log_error("stream still busy or offering words after its run");
    endtask

    task automatic check_pop(input int s, input logic rd, input logic rdy,
                             input prefetch_pkg::data_t data);
        a_no_extra: assert (!rdy || exp_rd[s] < exp_wr[s])
            else log_error($sformatf("stream %0d offers a word past its run", s));
        if (rd && rdy && exp_rd[s] < exp_wr[s]) begin
            a_order: assert (data == exp_data[s][exp_rd[s]])
                else log_error($sformatf("stream %0d word %0d is %h, expected %h",
                                         s, exp_rd[s], data, exp_data[s][exp_rd[s]]));
            exp_rd[s]++;
            pops++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Consumer, monitor and timeout
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (rand_rd) begin
            if (hold0 == 0)
                pick_stretch(lvl0, hold0);
            if (hold1 == 0)
                pick_stretch(lvl1, hold1);
            hold0 = hold0 - 1;
            hold1 = hold1 - 1;
            s0_rd <= lvl0;
            s1_rd <= lvl1;
        end else begin
            s0_rd <= 1'b1;
            s1_rd <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!srst) begin
            check_pop(0, s0_rd, s0_rd_rdy, s0_rd_data);
            check_pop(1, s1_rd, s1_rd_rdy, s1_rd_data);
        end
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("Timeout after %0d cycles, a run never completed", cycle);
            $display("=== FAIL ===");
            $finish;
        end
    end

    a_no_oflow: assert property (@(posedge clk) disable iff (srst) !s0_oflow && !s1_oflow)
        else log_error("prefetch buffer overflow flag set");

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        repeat (4) @(posedge clk);
        srst <= 1'b0;
        @(negedge clk);
        a_reset: assert (!s0_rd_rdy && !s1_rd_rdy && !s0_busy && !s1_busy
                         && !s0_oflow && !s1_oflow)
            else log_error("outputs not idle after reset");
        load_memory();
        // Stream 0 alone
        start_runs(1'b1, 8'h10, 8'd20, 1'b0, 8'h00, 8'd0);
        wait_runs_done();
        // Both streams, overlapping ranges, unequal lengths
        start_runs(1'b1, 8'h30, 8'd24, 1'b1, 8'h40, 8'd20);
        wait_runs_done();
        a_fair: assert (fall0 - fall1 <= (24 - 20) * 8 && fall1 - fall0 <= 0)
            else log_error("busy of one stream outlasted the other too long");
        // Long consumer stalls on fresh contents
        load_memory();
        @(negedge clk);
        rand_rd = 1'b1;
        start_runs(1'b1, 8'h80, 8'd24, 1'b1, 8'h88, 8'd24);
        wait_runs_done();
        rand_rd = 1'b0;
        // Restart of both streams after a reload
        load_memory();
        start_runs(1'b1, 8'he0, 8'd16, 1'b1, 8'h00, 8'd12);
        wait_runs_done();
        $display("Checked %0d words, %0d errors", pops, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule : tb_prefetch_subsystem

`default_nettype wire

/* src/prefetch_subsystem.sv */
// Top level of the dual-stream read prefetcher
// Two fetchers share the memory through the arbiter, returns routed by tag

`default_nettype none

module prefetch_subsystem (
    input  logic                 clk,
    input  logic                 srst,
    // Memory load port
    input  logic                 load_en,
    input  prefetch_pkg::addr_t  load_addr,
    input  prefetch_pkg::data_t  load_data,
    // Stream 0
    input  logic                 s0_start,
    input  prefetch_pkg::addr_t  s0_base_addr,
    input  prefetch_pkg::count_t s0_word_count,
    output logic                 s0_busy,
    input  logic                 s0_rd,
    output logic                 s0_rd_rdy,
    output prefetch_pkg::data_t  s0_rd_data,
    output logic                 s0_oflow,
    // Stream 1
    input  logic                 s1_start,
    input  prefetch_pkg::addr_t  s1_base_addr,
    input  prefetch_pkg::count_t s1_word_count,
    output logic                 s1_busy,
    input  logic                 s1_rd,
    output logic                 s1_rd_rdy,
    output prefetch_pkg::data_t  s1_rd_data,
    output logic                 s1_oflow
);

    // -----------------------------------------------------------------------
    // Interconnect
    // -----------------------------------------------------------------------
    logic                     req0, req1, ack0, ack1;
    prefetch_pkg::addr_t      addr0, addr1;
    logic                     room0, room1;
    logic                     mem_rd;
    prefetch_pkg::addr_t      mem_rd_addr;
    prefetch_pkg::stream_id_t mem_rd_tag;
    logic                     ret_valid;
    prefetch_pkg::data_t      ret_data;
    prefetch_pkg::stream_id_t ret_tag;
    logic                     wr0, wr1;

    stream_fetcher u_fetch0 (
        .clk, .srst,
        .start (s0_start), .base_addr (s0_base_addr), .word_count (s0_word_count),
        .busy  (s0_busy),  .room (room0),
        .req   (req0),     .addr (addr0), .ack (ack0)
    );

    stream_fetcher u_fetch1 (
        .clk, .srst,
        .start (s1_start), .base_addr (s1_base_addr), .word_count (s1_word_count),
        .busy  (s1_busy),  .room (room1),
        .req   (req1),     .addr (addr1), .ack (ack1)
    );

    read_arbiter u_arb (
        .clk, .srst,
        .req0, .addr0, .ack0,
        .req1, .addr1, .ack1,
        .mem_rd, .mem_rd_addr, .mem_rd_tag
    );

    shared_memory u_mem (
        .clk, .srst,
        .load_en, .load_addr, .load_data,
        .mem_rd, .mem_rd_addr, .mem_rd_tag,
        .ret_valid, .ret_data, .ret_tag
    );

    // Return goes only to the buffer named by its tag
    assign wr0 = ret_valid && (ret_tag == 1'b0);
    assign wr1 = ret_valid && (ret_tag == 1'b1);

    prefetch_buffer u_buf0 (
        .clk, .srst,
        .wr (wr0), .wr_data (ret_data), .wr_rdy (room0), .oflow (s0_oflow),
        .rd (s0_rd), .rd_rdy (s0_rd_rdy), .rd_data (s0_rd_data)
    );

    prefetch_buffer u_buf1 (
        .clk, .srst,
        .wr (wr1), .wr_data (ret_data), .wr_rdy (room1), .oflow (s1_oflow),
        .rd (s1_rd), .rd_rdy (s1_rd_rdy), .rd_data (s1_rd_data)
    );

endmodule : prefetch_subsystem

`default_nettype wire

/* src/shared_memory.sv */
// Shared on-chip RAM with a load write port
// Fixed-latency read pipeline carrying the requesting stream's tag

`default_nettype none

`include "prefetch_config.svh"

module shared_memory (
    input  logic                     clk,
    input  logic                     srst,
    // Load port, used only while streams are idle
    input  logic                     load_en,
    input  prefetch_pkg::addr_t      load_addr,
    input  prefetch_pkg::data_t      load_data,
    // Read request from the arbiter
    input  logic                     mem_rd,
    input  prefetch_pkg::addr_t      mem_rd_addr,
    input  prefetch_pkg::stream_id_t mem_rd_tag,
    // Tagged return
    output logic                     ret_valid,
    output prefetch_pkg::data_t      ret_data,
    output prefetch_pkg::stream_id_t ret_tag
);

    localparam int LAT = `PF_MEM_LATENCY;

    prefetch_pkg::data_t      mem [`PF_MEM_WORDS];
    logic [LAT-1:0]           pipe_vld;
    prefetch_pkg::data_t      pipe_data [LAT];
    prefetch_pkg::stream_id_t pipe_tag [LAT];

    always_ff @(posedge clk) begin
        if (load_en)
            mem[load_addr] <= load_data;
    end

    // Valid stages are control, cleared on reset
    always_ff @(posedge clk) begin
        if (srst)
            pipe_vld <= '0;
        else
            pipe_vld <= {pipe_vld[LAT-2:0], mem_rd};
    end

    // First stage does the lookup, the rest only delay
    always_ff @(posedge clk) begin
        pipe_data[0] <= mem[mem_rd_addr];
        pipe_tag[0]  <= mem_rd_tag;
        for (int i = 1; i < LAT; i++) begin
            pipe_data[i] <= pipe_data[i-1];
            pipe_tag[i]  <= pipe_tag[i-1];
        end
    end

    assign ret_valid = pipe_vld[LAT-1];
    assign ret_data  = pipe_data[LAT-1];
    assign ret_tag   = pipe_tag[LAT-1];

endmodule : shared_memory

`default_nettype wire

/* src/read_arbiter.sv */
// Two-way round-robin arbiter for the memory read port
// Acks each fetcher in the cycle its address is issued

`default_nettype none

module read_arbiter (
    input  logic                     clk,
    input  logic                     srst,
    // Stream 0 link
    input  logic                     req0,
    input  prefetch_pkg::addr_t      addr0,
    output logic                     ack0,
    // Stream 1 link
    input  logic                     req1,
    input  prefetch_pkg::addr_t      addr1,
    output logic                     ack1,
    // Memory read port
    output logic                     mem_rd,
    output prefetch_pkg::addr_t      mem_rd_addr,
    output prefetch_pkg::stream_id_t mem_rd_tag
);

    prefetch_pkg::stream_id_t last_grant;
    prefetch_pkg::stream_id_t grant_id;
    logic                     elig0;
    logic                     elig1;
    logic                     grant_vld;

    // -----------------------------------------------------------------------
    // Grant selection
    // -----------------------------------------------------------------------
    // A stream competes only while its current req is still unacked
    assign elig0     = req0 && !ack0;
    assign elig1     = req1 && !ack1;
    assign grant_vld = elig0 || elig1;

    always_comb begin
        if (elig0 && elig1)
            // Tie goes to the stream not served last
            grant_id = ~last_grant;
        else if (elig1)
            grant_id = 1'b1;
        else
            grant_id = 1'b0;
    end

    // -----------------------------------------------------------------------
    // Ack and read strobe
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            ack0       <= 1'b0;
            ack1       <= 1'b0;
            mem_rd     <= 1'b0;
            last_grant <= 1'b1;
        end else begin
            mem_rd <= grant_vld;
            if (grant_vld)
                last_grant <= grant_id;
            // Raise on grant, release once the fetcher drops req
            if (grant_vld && grant_id == 1'b0)
                ack0 <= 1'b1;
            else if (ack0 && !req0)
                ack0 <= 1'b0;
            if (grant_vld && grant_id == 1'b1)
                ack1 <= 1'b1;
            else if (ack1 && !req1)
                ack1 <= 1'b0;
        end
    end

    // Payload of the issued read
    always_ff @(posedge clk) begin
        if (grant_vld) begin
            mem_rd_addr <= (grant_id == 1'b1) ? addr1 : addr0;
            mem_rd_tag  <= grant_id;
        end
    end

endmodule : read_arbiter

`default_nettype wire

/* src/stream_fetcher.sv */
// Per-stream address generator
// Walks a run of consecutive words with a four-phase req/ack per word

`default_nettype none

module stream_fetcher (
    input  logic                 clk,
    input  logic                 srst,
    // Run control
    input  logic                 start,
    input  prefetch_pkg::addr_t  base_addr,
    input  prefetch_pkg::count_t word_count,
    output logic                 busy,
    // Headroom from the stream's buffer
    input  logic                 room,
    // Four-phase link to the arbiter
    output logic                 req,
    output prefetch_pkg::addr_t  addr,
    input  logic                 ack
);

    prefetch_pkg::fetch_state_t state;
    // Words not yet acknowledged
    prefetch_pkg::count_t       remain;

    // -----------------------------------------------------------------------
    // Handshake FSM
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state  <= prefetch_pkg::IDLE;
            remain <= '0;
            req    <= 1'b0;
            busy   <= 1'b0;
        end else begin
            case (state)
                prefetch_pkg::IDLE: begin
                    // Zero-length runs are ignored
                    if (start && word_count != '0) begin
                        remain <= word_count;
                        busy   <= 1'b1;
                        state  <= prefetch_pkg::WAIT_ROOM;
                    end
                end
                prefetch_pkg::WAIT_ROOM: begin
                    // New req only with headroom and ack already low
                    if (room && !ack) begin
                        req   <= 1'b1;
                        state <= prefetch_pkg::REQ;
                    end
                end
                prefetch_pkg::REQ: begin
                    if (ack) begin
                        req    <= 1'b0;
                        remain <= remain - 1'b1;
                        state  <= prefetch_pkg::WAIT_ACK_LOW;
                    end
                end
                prefetch_pkg::WAIT_ACK_LOW: begin
                    if (!ack) begin
                        if (remain == '0) begin
                            busy  <= 1'b0;
                            state <= prefetch_pkg::IDLE;
                        end else begin
                            state <= prefetch_pkg::WAIT_ROOM;
                        end
                    end
                end
                default: state <= prefetch_pkg::IDLE;
            endcase
        end
    end

    // Address is payload, held stable while req is high
    always_ff @(posedge clk) begin
        if (state == prefetch_pkg::IDLE && start)
            addr <= base_addr;
        else if (state == prefetch_pkg::REQ && ack)
            addr <= addr + 1'b1;  // Next word once this one is issued
    end

endmodule : stream_fetcher

`default_nettype wire

/* src/prefetch_buffer.sv */
// Small synchronous prefetch FIFO for one stream
// Tracks reads still in flight so wr_rdy leaves headroom for them

`default_nettype none

`include "prefetch_config.svh"

module prefetch_buffer (
    input  logic                clk,
    input  logic                srst,
    // Returns from memory
    input  logic                wr,
    input  prefetch_pkg::data_t wr_data,
    output logic                wr_rdy,
    output logic                oflow,
    // Consumer side
    input  logic                rd,
    output logic                rd_rdy,
    output prefetch_pkg::data_t rd_data
);

    // -----------------------------------------------------------------------
    // Sizing
    // -----------------------------------------------------------------------
    localparam int PIPE_DEPTH = `PF_PIPE_DEPTH;
    localparam int DEPTH      = `PF_BUF_DEPTH;
    localparam int PTR_W      = $clog2(DEPTH);
    localparam int MEM_SLOTS  = 2 ** PTR_W;
    localparam int CNT_W      = $clog2(DEPTH + 1);
    localparam int RES_W      = $clog2(PIPE_DEPTH + 1);

    prefetch_pkg::data_t   mem [MEM_SLOTS];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic [CNT_W:0]        occupancy;
    logic                  full;
    logic                  wr_safe;
    logic                  rd_safe;
    // One bit per cycle that wr_rdy was offered, oldest at the top
    logic [PIPE_DEPTH-1:0] res_vec;
    logic [RES_W-1:0]      res_cnt;

    assign full    = (count == CNT_W'(DEPTH));
    // Drop writes into a full buffer, ignore reads of an empty one
    assign wr_safe = wr && !full;
    assign rd_safe = rd && rd_rdy;

    // -----------------------------------------------------------------------
    // Pointers and occupancy
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            oflow  <= 1'b0;
        end else begin
            // Pointers wrap at the power-of-two slot count
            if (wr_safe)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_safe)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_safe, rd_safe})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky, the sender broke the headroom contract
            if (wr && full)
                oflow <= 1'b1;
        end
    end

    // -----------------------------------------------------------------------
    // Reservations for reads that may still be in flight
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            res_vec <= '0;
            res_cnt <= '0;
        end else begin
            res_vec <= {res_vec[PIPE_DEPTH-2:0], wr_rdy};
            // Add the new offer, retire the one leaving the window
            if (wr_rdy && !res_vec[PIPE_DEPTH-1])
                res_cnt <= res_cnt + 1'b1;
            else if (!wr_rdy && res_vec[PIPE_DEPTH-1])
                res_cnt <= res_cnt - 1'b1;
        end
    end

    assign occupancy = {1'b0, count} + (CNT_W + 1)'(res_cnt);
    assign wr_rdy    = (occupancy < (CNT_W + 1)'(DEPTH));

    // -----------------------------------------------------------------------
    // Storage
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_safe)
            mem[wr_ptr] <= wr_data;
    end

    // Head word visible as soon as count is non-zero
    assign rd_data = mem[rd_ptr];
    assign rd_rdy  = (count != '0);

endmodule : prefetch_buffer

`default_nettype wire

/* src/prefetch_pkg.sv */
// Shared types of the prefetcher
// Address, data, run length, stream tag and fetcher FSM states

`default_nettype none

`include "prefetch_config.svh"

package prefetch_pkg;

    // Word address into the shared memory
    typedef logic [`PF_ADDR_W-1:0] addr_t;

    // One memory word
    typedef logic [`PF_DATA_W-1:0] data_t;

    // Number of words in one stream run
    typedef logic [`PF_CNT_W-1:0]  count_t;

    // Stream tag, 0 or 1
    typedef logic [0:0]            stream_id_t;

    // Per-word handshake sequence of a fetcher
    typedef enum logic [1:0] {
        IDLE         = 2'd0,
        WAIT_ROOM    = 2'd1,
        REQ          = 2'd2,
        WAIT_ACK_LOW = 2'd3
    } fetch_state_t;

endpackage : prefetch_pkg

`default_nettype wire

/* src/prefetch_config.svh */
// Width, depth and latency constants for the dual-stream prefetcher
// Shared by the package and the RTL that sizes storage or pipelines

`ifndef PREFETCH_CONFIG_SVH
`define PREFETCH_CONFIG_SVH

// ---------------------------------------------------------------------------
// Memory geometry
// ---------------------------------------------------------------------------
`define PF_ADDR_W       8
`define PF_DATA_W       16
`define PF_MEM_WORDS    256

// Cycles from mem_rd to ret_valid
`define PF_MEM_LATENCY  2

// ---------------------------------------------------------------------------
// Prefetch sizing
// ---------------------------------------------------------------------------
// Writes still landing after wr_rdy drops
// Ready sample, req register and arbiter issue on top of the RAM latency
`define PF_PIPE_DEPTH   (`PF_MEM_LATENCY + 3)
`define PF_BUF_DEPTH    (2 * `PF_PIPE_DEPTH)
// Words per stream run
`define PF_CNT_W        8

`endif
